/* hdl/harness_pkg.sv */
`default_nettype none

package harness_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned DATA_W   = 64;
  localparam int unsigned BE_W     = DATA_W / 8;
  localparam int unsigned OFFSET_W = $clog2(BE_W);

  // --------------------------------------------------
  // Memory map
  // --------------------------------------------------
  localparam int unsigned REGION_W    = 4;
  localparam logic [3:0]  REGION_ROM  = 4'h0;
  localparam logic [3:0]  REGION_DRAM = 4'h8;

  localparam int unsigned ROM_WORDS  = 256;
  localparam int unsigned SRAM_WORDS = 1024;
  localparam int unsigned ROM_AW     = $clog2(ROM_WORDS);
  localparam int unsigned SRAM_AW    = $clog2(SRAM_WORDS);

  // Upper half of every boot ROM word
  localparam logic [31:0] ROM_TAG = 32'hB007_C0DE;

  // Halt request held off this long after reset
  localparam int unsigned DBG_DELAY_CYCLES = 50;

  // Address word, either raw or split into its decode fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [REGION_W-1:0]                           region;
      logic [ADDR_W-REGION_W-SRAM_AW-OFFSET_W-1:0]   unused;
      logic [SRAM_AW-1:0]                            word;
      logic [OFFSET_W-1:0]                           offset;
    } fields;
  } bus_addr_u;

endpackage

`default_nettype wire

/* hdl/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  // Core master
  input  wire logic                         core_req_i,
  input  wire logic                         core_we_i,
  input  wire harness_pkg::bus_addr_u       core_addr_i,
  input  wire logic [harness_pkg::BE_W-1:0]   core_be_i,
  input  wire logic [harness_pkg::DATA_W-1:0] core_wdata_i,
  output logic                              core_gnt_o,
  output logic                              core_rvalid_o,
  output logic [harness_pkg::DATA_W-1:0]    core_rdata_o,
  output logic                              core_err_o,
  // Debug master
  input  wire logic                         dbg_req_i,
  input  wire logic                         dbg_we_i,
  input  wire harness_pkg::bus_addr_u       dbg_addr_i,
  input  wire logic [harness_pkg::BE_W-1:0]   dbg_be_i,
  input  wire logic [harness_pkg::DATA_W-1:0] dbg_wdata_i,
  output logic                              dbg_gnt_o,
  output logic                              dbg_rvalid_o,
  output logic [harness_pkg::DATA_W-1:0]    dbg_rdata_o,
  output logic                              dbg_err_o,
  // Shared bus
  output logic                              bus_req_o,
  output logic                              bus_we_o,
  output harness_pkg::bus_addr_u            bus_addr_o,
  output logic [harness_pkg::BE_W-1:0]      bus_be_o,
  output logic [harness_pkg::DATA_W-1:0]    bus_wdata_o,
  input  wire logic                         bus_rvalid_i,
  input  wire logic [harness_pkg::DATA_W-1:0] bus_rdata_i,
  input  wire logic                         bus_err_i
);

  logic core_win;
  logic dbg_win;
  logic last_core_q;
  logic owner_dbg_q;

  // --------------------------------------------------
  // Round-robin pick
  // --------------------------------------------------
  // On a tie the core wins unless it had the last grant
  assign core_win = core_req_i & (~dbg_req_i | ~last_core_q);
  assign dbg_win  = dbg_req_i & ~core_win;

  assign core_gnt_o = core_win;
  assign dbg_gnt_o  = dbg_win;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_core_q <= 1'b0;
      owner_dbg_q <= 1'b0;
    end else begin
      if (core_win || dbg_win) begin
        last_core_q <= core_win;
      end
      // Owner of the response due next cycle
      owner_dbg_q <= dbg_win;
    end
  end

  // Winner onto the shared bus
  assign bus_req_o      = core_win | dbg_win;
  assign bus_we_o       = dbg_win ? dbg_we_i : core_we_i;
  assign bus_addr_o.raw = dbg_win ? dbg_addr_i.raw : core_addr_i.raw;
  assign bus_be_o       = dbg_win ? dbg_be_i : core_be_i;
  assign bus_wdata_o    = dbg_win ? dbg_wdata_i : core_wdata_i;

  // --------------------------------------------------
  // Response steering
  // --------------------------------------------------
  assign core_rvalid_o = bus_rvalid_i & ~owner_dbg_q;
  assign core_rdata_o  = owner_dbg_q ? '0 : bus_rdata_i;
  assign core_err_o    = bus_err_i & ~owner_dbg_q;

  assign dbg_rvalid_o = bus_rvalid_i & owner_dbg_q;
  assign dbg_rdata_o  = owner_dbg_q ? bus_rdata_i : '0;
  assign dbg_err_o    = bus_err_i & owner_dbg_q;

  a_one_grant : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(core_gnt_o && dbg_gnt_o)
  );

endmodule

`default_nettype wire

/* hdl/bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire logic                            bus_req_i,
  input  wire logic                            bus_we_i,
  input  wire harness_pkg::bus_addr_u          bus_addr_i,
  input  wire logic [harness_pkg::BE_W-1:0]    bus_be_i,
  input  wire logic [harness_pkg::DATA_W-1:0]  bus_wdata_i,
  input  wire logic [harness_pkg::DATA_W-1:0]  rom_rdata_i,
  input  wire logic [harness_pkg::DATA_W-1:0]  sram_rdata_i,
  output logic                                 rom_req_o,
  output logic [harness_pkg::ROM_AW-1:0]       rom_word_o,
  output logic                                 sram_req_o,
  output logic                                 sram_we_o,
  output logic [harness_pkg::SRAM_AW-1:0]      sram_word_o,
  output logic [harness_pkg::BE_W-1:0]         sram_be_o,
  output logic [harness_pkg::DATA_W-1:0]       sram_wdata_o,
  output logic                                 bus_rvalid_o,
  output logic [harness_pkg::DATA_W-1:0]       bus_rdata_o,
  output logic                                 bus_err_o
);

  import harness_pkg::*;

  logic is_rom;
  logic is_dram;
  logic rom_bad;
  logic dec_err;
  logic valid_q;
  logic err_q;
  logic rd_rom_q;
  logic rd_sram_q;

  // --------------------------------------------------
  // Region decode
  // --------------------------------------------------
  assign is_rom  = (bus_addr_i.fields.region == REGION_ROM);
  assign is_dram = (bus_addr_i.fields.region == REGION_DRAM);

  // ROM is read only and smaller than the index field
  assign rom_bad = is_rom & ((bus_addr_i.fields.word >= ROM_WORDS) | bus_we_i);
  assign dec_err = ~(is_rom | is_dram) | rom_bad;

  assign rom_req_o  = bus_req_i & is_rom & ~rom_bad;
  assign rom_word_o = bus_addr_i.fields.word[ROM_AW-1:0];

  assign sram_req_o   = bus_req_i & is_dram;
  assign sram_we_o    = bus_we_i;
  assign sram_word_o  = bus_addr_i.fields.word;
  assign sram_be_o    = bus_be_i;
  assign sram_wdata_o = bus_wdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      err_q     <= 1'b0;
      rd_rom_q  <= 1'b0;
      rd_sram_q <= 1'b0;
    end else begin
      valid_q   <= bus_req_i;
      err_q     <= bus_req_i & dec_err;
      rd_rom_q  <= rom_req_o;
      rd_sram_q <= sram_req_o & ~bus_we_i;
    end
  end

  // Writes and errors answer with zero data
  assign bus_rvalid_o = valid_q;
  assign bus_err_o    = err_q;
  assign bus_rdata_o  = rd_rom_q  ? rom_rdata_i :
                        rd_sram_q ? sram_rdata_i : '0;

  a_rvalid_follows_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni) bus_rvalid_o == $past(bus_req_i)
  );

endmodule

`default_nettype wire

/* hdl/boot_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  wire logic                           clk_i,
  input  wire logic                           req_i,
  input  wire logic [harness_pkg::ROM_AW-1:0] word_i,
  output logic [harness_pkg::DATA_W-1:0]      rdata_o
);

  import harness_pkg::*;

  logic [DATA_W-1:0] rom_word;

  // Fixed pattern
  // tag on top, word index at the bottom
  always_comb begin
    rom_word = '0;
    rom_word[DATA_W-1 -: 32] = ROM_TAG;
    rom_word[ROM_AW-1:0]     = word_i;
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom_word;
    end
  end

endmodule

`default_nettype wire

/* hdl/data_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_sram (
  input  wire logic                            clk_i,
  input  wire logic                            req_i,
  input  wire logic                            we_i,
  input  wire logic [harness_pkg::SRAM_AW-1:0] word_i,
  input  wire logic [harness_pkg::BE_W-1:0]    be_i,
  input  wire logic [harness_pkg::DATA_W-1:0]  wdata_i,
  output logic [harness_pkg::DATA_W-1:0]       rdata_o
);

  import harness_pkg::*;

  logic [DATA_W-1:0] mem [SRAM_WORDS];

  // --------------------------------------------------
  // Byte-enabled write, registered read
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < BE_W; b++) begin
          if (be_i[b]) begin
            mem[word_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[word_i];
      end
    end
  end

  a_word_known : assert property (
    @(posedge clk_i) req_i |-> !$isunknown(word_i)
  );

endmodule

`default_nettype wire

/* hdl/debug_req_gate.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_req_gate (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic debug_req_i,
  input  wire logic debug_enable_i,
  output logic      debug_req_o
);

  import harness_pkg::*;

  logic [$clog2(DBG_DELAY_CYCLES+1)-1:0] cnt_q;

  // Countdown from reset, stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= DBG_DELAY_CYCLES[$bits(cnt_q)-1:0];
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Gives the boot code a head start before any halt
  assign debug_req_o = (cnt_q == '0) & debug_enable_i & debug_req_i;

endmodule

`default_nettype wire

/* hdl/soc_harness.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_harness (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  // Core port
  input  wire logic                            core_req_i,
  input  wire logic                            core_we_i,
  input  wire logic [harness_pkg::ADDR_W-1:0]  core_addr_i,
  input  wire logic [harness_pkg::BE_W-1:0]    core_be_i,
  input  wire logic [harness_pkg::DATA_W-1:0]  core_wdata_i,
  output logic                                 core_gnt_o,
  output logic                                 core_rvalid_o,
  output logic [harness_pkg::DATA_W-1:0]       core_rdata_o,
  output logic                                 core_err_o,
  // Debug system-bus port
  input  wire logic                            dbg_req_i,
  input  wire logic                            dbg_we_i,
  input  wire logic [harness_pkg::ADDR_W-1:0]  dbg_addr_i,
  input  wire logic [harness_pkg::BE_W-1:0]    dbg_be_i,
  input  wire logic [harness_pkg::DATA_W-1:0]  dbg_wdata_i,
  output logic                                 dbg_gnt_o,
  output logic                                 dbg_rvalid_o,
  output logic [harness_pkg::DATA_W-1:0]       dbg_rdata_o,
  output logic                                 dbg_err_o,
  // Halt request
  input  wire logic                            debug_req_i,
  input  wire logic                            debug_enable_i,
  output logic                                 debug_req_o
);

  import harness_pkg::*;

  // --------------------------------------------------
  // Shared bus
  // --------------------------------------------------
  logic              bus_req;
  logic              bus_we;
  bus_addr_u         bus_addr;
  logic [BE_W-1:0]   bus_be;
  logic [DATA_W-1:0] bus_wdata;
  logic              bus_rvalid;
  logic [DATA_W-1:0] bus_rdata;
  logic              bus_err;

  // Target side
  logic               rom_req;
  logic [ROM_AW-1:0]  rom_word;
  logic [DATA_W-1:0]  rom_rdata;
  logic               sram_req;
  logic               sram_we;
  logic [SRAM_AW-1:0] sram_word;
  logic [BE_W-1:0]    sram_be;
  logic [DATA_W-1:0]  sram_wdata;
  logic [DATA_W-1:0]  sram_rdata;

  bus_arbiter i_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .core_req_i    (core_req_i),
    .core_we_i     (core_we_i),
    .core_addr_i   (core_addr_i),
    .core_be_i     (core_be_i),
    .core_wdata_i  (core_wdata_i),
    .core_gnt_o    (core_gnt_o),
    .core_rvalid_o (core_rvalid_o),
    .core_rdata_o  (core_rdata_o),
    .core_err_o    (core_err_o),
    .dbg_req_i     (dbg_req_i),
    .dbg_we_i      (dbg_we_i),
    .dbg_addr_i    (dbg_addr_i),
    .dbg_be_i      (dbg_be_i),
    .dbg_wdata_i   (dbg_wdata_i),
    .dbg_gnt_o     (dbg_gnt_o),
    .dbg_rvalid_o  (dbg_rvalid_o),
    .dbg_rdata_o   (dbg_rdata_o),
    .dbg_err_o     (dbg_err_o),
    .bus_req_o     (bus_req),
    .bus_we_o      (bus_we),
    .bus_addr_o    (bus_addr),
    .bus_be_o      (bus_be),
    .bus_wdata_o   (bus_wdata),
    .bus_rvalid_i  (bus_rvalid),
    .bus_rdata_i   (bus_rdata),
    .bus_err_i     (bus_err)
  );

  bus_decoder i_decoder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bus_req_i    (bus_req),
    .bus_we_i     (bus_we),
    .bus_addr_i   (bus_addr),
    .bus_be_i     (bus_be),
    .bus_wdata_i  (bus_wdata),
    .rom_rdata_i  (rom_rdata),
    .sram_rdata_i (sram_rdata),
    .rom_req_o    (rom_req),
    .rom_word_o   (rom_word),
    .sram_req_o   (sram_req),
    .sram_we_o    (sram_we),
    .sram_word_o  (sram_word),
    .sram_be_o    (sram_be),
    .sram_wdata_o (sram_wdata),
    .bus_rvalid_o (bus_rvalid),
    .bus_rdata_o  (bus_rdata),
    .bus_err_o    (bus_err)
  );

  // --------------------------------------------------
  // Targets
  // --------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i   (clk_i),
    .req_i   (rom_req),
    .word_i  (rom_word),
    .rdata_o (rom_rdata)
  );

  data_sram i_data_sram (
    .clk_i   (clk_i),
    .req_i   (sram_req),
    .we_i    (sram_we),
    .word_i  (sram_word),
    .be_i    (sram_be),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

  debug_req_gate i_debug_gate (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .debug_req_i    (debug_req_i),
    .debug_enable_i (debug_enable_i),
    .debug_req_o    (debug_req_o)
  );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held for 10 cycles, released just after an edge
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/tb_soc_harness.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_harness;

  import harness_pkg::*;

  localparam int MAX_ENTRIES = 32;
  localparam int PAIR_LEN    = 4;

  logic              clk;
  logic              rst_n;
  logic              core_req;
  logic              core_we;
  logic [ADDR_W-1:0] core_addr;
  logic [BE_W-1:0]   core_be;
  logic [DATA_W-1:0] core_wdata;
  logic              core_gnt;
  logic              core_rvalid;
  logic [DATA_W-1:0] core_rdata;
  logic              core_err;
  logic              dbg_req;
  logic              dbg_we;
  logic [ADDR_W-1:0] dbg_addr;
  logic [BE_W-1:0]   dbg_be;
  logic [DATA_W-1:0] dbg_wdata;
  logic              dbg_gnt;
  logic              dbg_rvalid;
  logic [DATA_W-1:0] dbg_rdata;
  logic              dbg_err;
  logic              debug_req;
  logic              debug_enable;
  logic              debug_req_out;

  // Stimulus table
  string             t_name [MAX_ENTRIES];
  logic              t_dbg [MAX_ENTRIES];
  logic              t_we [MAX_ENTRIES];
  logic [3:0]        t_region [MAX_ENTRIES];
  int                t_word [MAX_ENTRIES];
  logic [BE_W-1:0]   t_be [MAX_ENTRIES];
  logic              t_rnd [MAX_ENTRIES];
  logic [DATA_W-1:0] t_rdata [MAX_ENTRIES];
  logic              t_err [MAX_ENTRIES];
  int                n_entries;

  logic [DATA_W-1:0] sram_model [SRAM_WORDS];
  logic [31:0]       lfsr_state;
  int                err_count;
  int                tests_run;
  int                tests_failed;
  int                cycles;
  int                limit_cycles;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  soc_harness dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .core_req_i     (core_req),
    .core_we_i      (core_we),
    .core_addr_i    (core_addr),
    .core_be_i      (core_be),
    .core_wdata_i   (core_wdata),
    .core_gnt_o     (core_gnt),
    .core_rvalid_o  (core_rvalid),
    .core_rdata_o   (core_rdata),
    .core_err_o     (core_err),
    .dbg_req_i      (dbg_req),
    .dbg_we_i       (dbg_we),
    .dbg_addr_i     (dbg_addr),
    .dbg_be_i       (dbg_be),
    .dbg_wdata_i    (dbg_wdata),
    .dbg_gnt_o      (dbg_gnt),
    .dbg_rvalid_o   (dbg_rvalid),
    .dbg_rdata_o    (dbg_rdata),
    .dbg_err_o      (dbg_err),
    .debug_req_i    (debug_req),
    .debug_enable_i (debug_enable),
    .debug_req_o    (debug_req_out)
  );

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  // Right-shifting Galois LFSR, taps 32 30 26 25
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic rand_word(output logic [DATA_W-1:0] w);
    for (int b = 0; b < DATA_W; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[b] = lfsr_state[0];
    end
  endtask

  function automatic logic [DATA_W-1:0] rom_expect(input int k);
    return {ROM_TAG, 32'(k)};
  endfunction

  function automatic logic [ADDR_W-1:0] make_addr(input logic [3:0] region, input int word);
    bus_addr_u a;
    a.raw = '0;
    a.fields.region = region;
    a.fields.word = SRAM_AW'(word);
    return a.raw;
  endfunction

  task automatic check_value(input string name, input string what,
                             input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
    assert (act === exp) else begin
      $display("error: %s %s expected %h actual %h", name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond === 1'b1) else begin
      $display("%s", msg);
      err_count++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s failed", name);
    end
  endtask

  task automatic add_entry(input string name, input logic dbg, input logic we,
                           input logic [3:0] region, input int word, input logic [BE_W-1:0] be,
                           input logic rnd, input logic [DATA_W-1:0] rdata, input logic err);
    t_name[n_entries]   = name;
    t_dbg[n_entries]    = dbg;
    t_we[n_entries]     = we;
    t_region[n_entries] = region;
    t_word[n_entries]   = word;
    t_be[n_entries]     = be;
    t_rnd[n_entries]    = rnd;
    t_rdata[n_entries]  = rdata;
    t_err[n_entries]    = err;
    n_entries++;
  endtask

  // SRAM reads take their value from the model, so their column stays zero
  task automatic build_table();
    add_entry("sram_wr5", 0, 1, REGION_DRAM, 5, 8'hFF, 1, 64'd0, 0);
    add_entry("sram_rd5", 0, 0, REGION_DRAM, 5, 8'hFF, 0, 64'd0, 0);
    add_entry("sram_wr700", 1, 1, REGION_DRAM, 700, 8'hFF, 1, 64'd0, 0);
    add_entry("sram_rd700", 0, 0, REGION_DRAM, 700, 8'hFF, 0, 64'd0, 0);
    add_entry("sram_be_low", 0, 1, REGION_DRAM, 5, 8'h0F, 1, 64'd0, 0);
    add_entry("sram_be_mix", 1, 1, REGION_DRAM, 5, 8'hA5, 1, 64'd0, 0);
    add_entry("sram_rd_merge", 1, 0, REGION_DRAM, 5, 8'hFF, 0, 64'd0, 0);
    add_entry("rom_rd3", 0, 0, REGION_ROM, 3, 8'hFF, 0, rom_expect(3), 0);
    add_entry("rom_rd255", 1, 0, REGION_ROM, 255, 8'hFF, 0, rom_expect(255), 0);
    add_entry("rom_wr3", 0, 1, REGION_ROM, 3, 8'hFF, 1, 64'd0, 1);
    add_entry("rom_rd3_again", 1, 0, REGION_ROM, 3, 8'hFF, 0, rom_expect(3), 0);
    add_entry("unmapped_core", 0, 0, 4'h4, 12, 8'hFF, 0, 64'd0, 1);
    add_entry("unmapped_dbg", 1, 1, 4'hF, 12, 8'hFF, 1, 64'd0, 1);
    add_entry("rom_oob_core", 0, 0, REGION_ROM, 256, 8'hFF, 0, 64'd0, 1);
    add_entry("rom_oob_dbg", 1, 0, REGION_ROM, 1023, 8'hFF, 0, 64'd0, 1);
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic run_debug_gate_test();
    int errs_before;
    errs_before = err_count;
    @(posedge rst_n);
    for (int k = 1; k <= 60; k++) begin
      @(negedge clk);
      if (k == 1) begin
        check_true(!(core_gnt || dbg_gnt || core_rvalid || dbg_rvalid),
                   "reset: a grant or rvalid is high after reset");
      end
      if (k <= 40) begin
        check_value("debug_holdoff", "debug_req_o", 64'd0, debug_req_out);
      end
    end
    check_value("debug_release", "debug_req_o", 64'd1, debug_req_out);
    @(posedge clk);
    #1 debug_enable = 1'b0;
    @(negedge clk);
    check_value("debug_disable", "debug_req_o", 64'd0, debug_req_out);
    end_test("debug_gate", errs_before);
  endtask

  task automatic apply_entry(input int i);
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] exp;
    int errs_before;
    int waited;
    errs_before = err_count;
    wdata = '0;
    if (t_rnd[i]) begin
      rand_word(wdata);
    end
    @(posedge clk);
    #1;
    if (t_dbg[i]) begin
      dbg_req   = 1'b1;
      dbg_we    = t_we[i];
      dbg_addr  = make_addr(t_region[i], t_word[i]);
      dbg_be    = t_be[i];
      dbg_wdata = wdata;
    end else begin
      core_req   = 1'b1;
      core_we    = t_we[i];
      core_addr  = make_addr(t_region[i], t_word[i]);
      core_be    = t_be[i];
      core_wdata = wdata;
    end
    waited = 0;
    @(negedge clk);
    while (!(t_dbg[i] ? dbg_gnt : core_gnt) && waited < 4) begin
      waited++;
      @(negedge clk);
    end
    check_true(t_dbg[i] ? dbg_gnt : core_gnt, {t_name[i], ": request was never granted"});

    // Model follows the byte-enable rule for accepted writes
    if (t_we[i] && t_region[i] == REGION_DRAM && !t_err[i]) begin
      for (int b = 0; b < BE_W; b++) begin
        if (t_be[i][b]) begin
          sram_model[t_word[i]][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end
    if (t_we[i] || t_err[i]) begin
      exp = '0;
    end else if (t_region[i] == REGION_DRAM) begin
      exp = sram_model[t_word[i]];
    end else begin
      exp = t_rdata[i];
    end

    @(posedge clk);
    #1;
    core_req = 1'b0;
    dbg_req  = 1'b0;
    @(negedge clk);
    check_value(t_name[i], "rvalid", 64'd1, t_dbg[i] ? dbg_rvalid : core_rvalid);
    check_value(t_name[i], "other rvalid", 64'd0, t_dbg[i] ? core_rvalid : dbg_rvalid);
    check_value(t_name[i], "rdata", exp, t_dbg[i] ? dbg_rdata : core_rdata);
    check_value(t_name[i], "err", t_err[i], t_dbg[i] ? dbg_err : core_err);
    end_test(t_name[i], errs_before);
  endtask

  // Core reads SRAM, debug reads ROM, both always requesting
  task automatic run_pair_test();
    logic [DATA_W-1:0] core_exp [$];
    logic [DATA_W-1:0] dbg_exp [$];
    logic core_gnt_q;
    logic dbg_gnt_q;
    logic both_req;
    int core_sent;
    int dbg_sent;
    int core_got;
    int dbg_got;
    int last_port;
    int guard;
    int errs_before;
    errs_before = err_count;
    core_gnt_q = 1'b0;
    dbg_gnt_q = 1'b0;
    core_sent = 0;
    dbg_sent = 0;
    core_got = 0;
    dbg_got = 0;
    last_port = -1;
    guard = 0;
    @(posedge clk);
    #1;
    core_req  = 1'b1;
    core_we   = 1'b0;
    core_addr = make_addr(REGION_DRAM, 5);
    dbg_req   = 1'b1;
    dbg_we    = 1'b0;
    dbg_addr  = make_addr(REGION_ROM, 20);
    while ((core_got < PAIR_LEN || dbg_got < PAIR_LEN) && guard < 4 * PAIR_LEN) begin
      @(negedge clk);
      both_req = core_req & dbg_req;
      check_true(!(core_gnt && dbg_gnt), "pair: both grants high in one cycle");
      check_value("pair", "core rvalid", core_gnt_q, core_rvalid);
      check_value("pair", "debug rvalid", dbg_gnt_q, dbg_rvalid);
      if (core_rvalid && core_exp.size() > 0) begin
        check_value("pair", "core rdata", core_exp.pop_front(), core_rdata);
        core_got++;
      end
      if (dbg_rvalid && dbg_exp.size() > 0) begin
        check_value("pair", "debug rdata", dbg_exp.pop_front(), dbg_rdata);
        dbg_got++;
      end
      if (core_gnt) begin
        check_true(!(both_req && last_port == 0), "pair: core granted twice while debug waited");
        core_exp.push_back(sram_model[(core_sent % 2 == 0) ? 5 : 700]);
        core_sent++;
        last_port = 0;
      end
      if (dbg_gnt) begin
        check_true(!(both_req && last_port == 1), "pair: debug granted twice while core waited");
        dbg_exp.push_back(rom_expect(20 + dbg_sent));
        dbg_sent++;
        last_port = 1;
      end
      core_gnt_q = core_gnt;
      dbg_gnt_q = dbg_gnt;
      @(posedge clk);
      #1;
      // A new request follows right after each grant
      if (core_gnt_q) begin
        core_req  = (core_sent < PAIR_LEN);
        core_addr = make_addr(REGION_DRAM, (core_sent % 2 == 0) ? 5 : 700);
      end
      if (dbg_gnt_q) begin
        dbg_req  = (dbg_sent < PAIR_LEN);
        dbg_addr = make_addr(REGION_ROM, 20 + dbg_sent);
      end
      guard++;
    end
    check_true(core_got == PAIR_LEN && dbg_got == PAIR_LEN,
               "pair: not every request got its response");
    core_req = 1'b0;
    dbg_req  = 1'b0;
    end_test("pair_arbitration", errs_before);
  endtask

  // --------------------------------------------------
  // Run control
  // --------------------------------------------------
  always @(posedge clk) begin
    cycles++;
    if (limit_cycles > 0 && cycles >= limit_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", limit_cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    core_req     = 1'b0;
    core_we      = 1'b0;
    core_addr    = '0;
    core_be      = '0;
    core_wdata   = '0;
    dbg_req      = 1'b0;
    dbg_we       = 1'b0;
    dbg_addr     = '0;
    dbg_be       = '0;
    dbg_wdata    = '0;
    debug_req    = 1'b1;
    debug_enable = 1'b1;
    lfsr_state   = 32'd95173;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    n_entries    = 0;
    build_table();
    limit_cycles = n_entries * 8 + DBG_DELAY_CYCLES + 100;

    run_debug_gate_test();
    for (int i = 0; i < n_entries; i++) begin
      apply_entry(i);
    end
    run_pair_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hdl/harness_pkg.sv
hdl/bus_arbiter.sv
hdl/bus_decoder.sv
hdl/boot_rom.sv
hdl/data_sram.sv
hdl/debug_req_gate.sv
hdl/soc_harness.sv
bench/tb_clock_gen.sv
bench/tb_soc_harness.sv
